/* files.f */
hdl/mul_pkg.sv
hdl/booth_encoder.sv
hdl/wallace_column.sv
hdl/wallace_tree.sv
hdl/cla_block_4.sv
hdl/cla_adder_64.sv
hdl/booth_multiplier.sv
sim/tb_booth_multiplier.sv

/* Bender.yml */
package:
  name: booth_multiplier

sources:
  # package first, then leaf modules up to the top level
  - hdl/mul_pkg.sv
  - hdl/booth_encoder.sv
  - hdl/wallace_column.sv
  - hdl/wallace_tree.sv
  - hdl/cla_block_4.sv
  - hdl/cla_adder_64.sv
  - hdl/booth_multiplier.sv

  - target: simulation
    files:
      - sim/tb_booth_multiplier.sv

/* sim/tb_booth_multiplier.sv */
`timescale 1ns/10ps

module tb_booth_multiplier;

    localparam int RESET_CYCLES   = 16;
    localparam int FIXED_ENTRIES  = 20;
    localparam int RANDOM_ENTRIES = 40;
    localparam int NUM_ENTRIES    = FIXED_ENTRIES + RANDOM_ENTRIES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ENTRIES + 20;
    localparam int EXT_PAD        = mul_pkg::PRODUCT_W - mul_pkg::OPERAND_W;

    logic                  mul_clk;
    logic                  resetn;
    logic                  i_mul_signed;
    mul_pkg::mul_operand_t i_x;
    mul_pkg::mul_operand_t i_y;
    mul_pkg::mul_product_t o_result;

    // stimulus table applied one row per cycle
    logic                  tbl_mode [NUM_ENTRIES];
    mul_pkg::mul_operand_t tbl_x    [NUM_ENTRIES];
    mul_pkg::mul_operand_t tbl_y    [NUM_ENTRIES];
    bit                    tbl_pair [NUM_ENTRIES];  // same operands as previous row in other mode
    mul_pkg::mul_product_t got_tbl  [NUM_ENTRIES];

    int                    n_pass      = 0;
    int                    n_fail      = 0;
    int                    cycle_count = 0;
    logic [31:0]           rng_state   = 32'd96;

    booth_multiplier i_booth_multiplier (
        .mul_clk      (mul_clk),
        .resetn       (resetn),
        .i_mul_signed (i_mul_signed),
        .i_x          (i_x),
        .i_y          (i_y),
        .o_result     (o_result)
    );

    initial mul_clk = 1'b0;
    always #10 mul_clk = ~mul_clk;

    always @(posedge mul_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // low 64 bits of the product of the extended operands
    function automatic mul_pkg::mul_product_t ref_product(input logic mode,
                                                          input mul_pkg::mul_operand_t x,
                                                          input mul_pkg::mul_operand_t y);
        mul_pkg::mul_product_t xe;
        mul_pkg::mul_product_t ye;
        xe = {{EXT_PAD{mode & x[mul_pkg::OPERAND_W-1]}}, x};
        ye = {{EXT_PAD{mode & y[mul_pkg::OPERAND_W-1]}}, y};
        return xe * ye;
    endfunction

    // unsigned minus signed product is 2^32 * (x31*y + y31*x) mod 2^64
    function automatic mul_pkg::mul_product_t mode_delta(input mul_pkg::mul_operand_t x,
                                                         input mul_pkg::mul_operand_t y);
        mul_pkg::mul_product_t acc;
        acc = '0;
        if (x[mul_pkg::OPERAND_W-1])
            acc = acc + {{EXT_PAD{1'b0}}, y};
        if (y[mul_pkg::OPERAND_W-1])
            acc = acc + {{EXT_PAD{1'b0}}, x};
        return acc << mul_pkg::OPERAND_W;
    endfunction

    task automatic check_product(input string what, input int idx,
                                 input mul_pkg::mul_product_t exp,
                                 input mul_pkg::mul_product_t got);
        if (got === exp) begin
            n_pass++;
            $display("%s %0d ok: %h", what, idx, got);
        end else begin
            n_fail++;
            $display("[ERROR] %0t: %s %0d expected %h, got %h", $time, what, idx, exp, got);
        end
    endtask

    task automatic set_entry(input int idx, input logic mode, input mul_pkg::mul_operand_t x,
                             input mul_pkg::mul_operand_t y, input bit pair);
        tbl_mode[idx] = mode;
        tbl_x[idx]    = x;
        tbl_y[idx]    = y;
        tbl_pair[idx] = pair;
    endtask

    task automatic load_table();
        logic [31:0] a;
        logic [31:0] b;
        // unsigned corners
        set_entry(0,  1'b0, 32'h0000_0000, 32'h0000_0000, 0);
        set_entry(1,  1'b0, 32'h0000_0001, 32'h0000_0001, 0);
        set_entry(2,  1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
        set_entry(3,  1'b0, 32'h8000_0000, 32'h8000_0000, 0);
        set_entry(4,  1'b0, 32'h8000_0000, 32'h0000_0001, 0);
        set_entry(5,  1'b0, 32'hFFFF_FFFF, 32'h0000_0002, 0);
        set_entry(6,  1'b0, 32'h1234_5678, 32'h9ABC_DEF0, 0);
        // signed corners
        set_entry(7,  1'b1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0);
        set_entry(8,  1'b1, 32'hFFFF_FFFF, 32'h0000_0001, 0);
        set_entry(9,  1'b1, 32'h8000_0000, 32'h8000_0000, 0);
        set_entry(10, 1'b1, 32'h8000_0000, 32'h7FFF_FFFF, 0);
        set_entry(11, 1'b1, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 0);
        set_entry(12, 1'b1, 32'hFFFF_FFF9, 32'h0000_0006, 0);  // -7 * 6
        set_entry(13, 1'b1, 32'h0000_0005, 32'hFFFF_FFFD, 0);
        // mode flips every cycle on fixed operands
        set_entry(14, 1'b0, 32'h8000_0001, 32'hFFFF_FFFE, 0);
        set_entry(15, 1'b1, 32'h8000_0001, 32'hFFFF_FFFE, 1);
        set_entry(16, 1'b0, 32'h8000_0001, 32'hFFFF_FFFE, 1);
        set_entry(17, 1'b1, 32'h8000_0001, 32'hFFFF_FFFE, 1);
        set_entry(18, 1'b0, 32'hDEAD_BEEF, 32'hCAFE_F00D, 0);
        set_entry(19, 1'b1, 32'hDEAD_BEEF, 32'hCAFE_F00D, 1);
        for (int k = 0; k < RANDOM_ENTRIES; k++) begin
            rng_state = xorshift32(rng_state);
            a         = rng_state;
            rng_state = xorshift32(rng_state);
            b         = rng_state;
            set_entry(FIXED_ENTRIES + k, k[0], a, b, 0);
        end
    endtask

    task automatic drive_entry(input int idx);
        i_mul_signed = tbl_mode[idx];
        i_x          = tbl_x[idx];
        i_y          = tbl_y[idx];
    endtask

    initial begin
        mul_pkg::mul_product_t got;
        mul_pkg::mul_product_t u_res;
        mul_pkg::mul_product_t s_res;

        resetn       = 1'b0;
        i_mul_signed = 1'b1;
        i_x          = 32'hFFFF_FFFF;  // nonzero operands while held in reset
        i_y          = 32'h8000_0000;
        load_table();

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge mul_clk);
            @(negedge mul_clk);
            check_product("reset cycle", c, '0, o_result);
        end

        resetn = 1'b1;
        drive_entry(0);
        #1;
        check_product("after release", 0, '0, o_result);  // flag still set from last edge

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(negedge mul_clk);
            got        = o_result;
            got_tbl[i] = got;
            check_product("entry", i, ref_product(tbl_mode[i], tbl_x[i], tbl_y[i]), got);
            if (tbl_pair[i]) begin
                u_res = tbl_mode[i] ? got_tbl[i-1] : got_tbl[i];
                s_res = tbl_mode[i] ? got_tbl[i] : got_tbl[i-1];
                check_product("mode delta", i, mode_delta(tbl_x[i], tbl_y[i]), u_res - s_res);
            end
            if (i + 1 < NUM_ENTRIES)
                drive_entry(i + 1);
        end

        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* hdl/booth_multiplier.sv */
`timescale 1ns/10ps

module booth_multiplier (
    input  logic                  mul_clk,
    input  logic                  resetn,
    input  logic                  i_mul_signed,
    input  mul_pkg::mul_operand_t i_x,
    input  mul_pkg::mul_operand_t i_y,
    output mul_pkg::mul_product_t o_result
);

    mul_pkg::pp_row_t      rows [0:mul_pkg::PP_ROWS-1];
    mul_pkg::pp_neg_t      neg;
    mul_pkg::tree_vec_t    tree_sum;
    mul_pkg::tree_vec_t    tree_carry;
    logic [1:0]            neg_late;
    mul_pkg::mul_product_t add_b;
    mul_pkg::mul_product_t add_sum;
    logic                  rst_dly;  // resetn was low at the last edge

    booth_encoder i_booth_encoder (
        .i_x          (i_x),
        .i_y          (i_y),
        .i_mul_signed (i_mul_signed),
        .o_rows       (rows),
        .o_neg        (neg)
    );

    wallace_tree i_wallace_tree (
        .i_clk      (mul_clk),
        .i_resetn   (resetn),
        .i_rows     (rows),
        .i_neg      (neg),
        .o_sum      (tree_sum),
        .o_carry    (tree_carry),
        .o_neg_late (neg_late)
    );

    // carries weigh one bit up so the spare lsb slot takes negate 15
    assign add_b = {tree_carry[mul_pkg::PRODUCT_W-2:0], neg_late[0]};

    cla_adder_64 i_cla_adder_64 (
        .i_a   (tree_sum[mul_pkg::PRODUCT_W-1:0]),
        .i_b   (add_b),
        .i_cin (neg_late[1]),
        .o_sum (add_sum)
    );

    always_ff @(posedge mul_clk) begin
        rst_dly <= ~resetn;
    end

    assign o_result = rst_dly ? '0 : add_sum;

    // flag set means the tree still holds its reset zeros
    a_reset_zero : assert property (@(posedge mul_clk)
        rst_dly |-> (add_sum == '0));

endmodule

/* hdl/cla_adder_64.sv */
`timescale 1ns/10ps

module cla_adder_64 (
    input  mul_pkg::mul_product_t i_a,
    input  mul_pkg::mul_product_t i_b,
    input  logic                  i_cin,
    output mul_pkg::mul_product_t o_sum
);

    mul_pkg::mul_product_t p0;
    mul_pkg::mul_product_t g0;
    mul_pkg::mul_product_t c_bit;  // carry into each bit
    logic [15:0]           p1;
    logic [15:0]           g1;
    logic [15:0]           c_grp;  // carry into each nibble
    logic [3:0]            p2;
    logic [3:0]            g2;
    logic [3:0]            c_sup;  // carry into each 16-bit block

    assign p0 = i_a | i_b;
    assign g0 = i_a & i_b;

    // top level, resolves the four 16-bit blocks
    cla_block_4 i_cla_level2 (
        .i_c0 (i_cin),
        .i_p  (p2),
        .i_g  (g2),
        .o_c  (c_sup[3:1]),
        .o_gp (),
        .o_gg ()
    );

    assign c_sup[0] = i_cin;

    for (genvar k = 0; k < 4; k++) begin : g_level1
        cla_block_4 i_cla_block_4 (
            .i_c0 (c_sup[k]),
            .i_p  (p1[4*k +: 4]),
            .i_g  (g1[4*k +: 4]),
            .o_c  (c_grp[4*k+1 +: 3]),
            .o_gp (p2[k]),
            .o_gg (g2[k])
        );

        assign c_grp[4*k] = c_sup[k];
    end

    for (genvar j = 0; j < 16; j++) begin : g_level0
        cla_block_4 i_cla_block_4 (
            .i_c0 (c_grp[j]),
            .i_p  (p0[4*j +: 4]),
            .i_g  (g0[4*j +: 4]),
            .o_c  (c_bit[4*j+1 +: 3]),
            .o_gp (p1[j]),
            .o_gg (g1[j])
        );

        assign c_bit[4*j] = c_grp[j];
    end

    // carry out of bit 63 dropped, product wraps
    assign o_sum = i_a ^ i_b ^ c_bit;

endmodule

/* hdl/cla_block_4.sv */
`timescale 1ns/10ps

module cla_block_4 (
    input  logic       i_c0,
    input  logic [3:0] i_p,
    input  logic [3:0] i_g,
    output logic [2:0] o_c,   // carries into bits 1..3
    output logic       o_gp,
    output logic       o_gg
);

    assign o_c[0] = i_g[0]
                  | (i_p[0] & i_c0);
    assign o_c[1] = i_g[1]
                  | (i_p[1] & i_g[0])
                  | (i_p[1] & i_p[0] & i_c0);
    assign o_c[2] = i_g[2]
                  | (i_p[2] & i_g[1])
                  | (i_p[2] & i_p[1] & i_g[0])
                  | (i_p[2] & i_p[1] & i_p[0] & i_c0);

    // group terms for the next level up
    assign o_gp = &i_p;
    assign o_gg = i_g[3]
                | (i_p[3] & i_g[2])
                | (i_p[3] & i_p[2] & i_g[1])
                | (i_p[3] & i_p[2] & i_p[1] & i_g[0]);

endmodule

/* hdl/wallace_tree.sv */
`timescale 1ns/10ps

module wallace_tree (
    input  logic                i_clk,
    input  logic                i_resetn,
    input  mul_pkg::pp_row_t    i_rows [0:mul_pkg::PP_ROWS-1],
    input  mul_pkg::pp_neg_t    i_neg,
    output mul_pkg::tree_vec_t  o_sum,
    output mul_pkg::tree_vec_t  o_carry,
    output logic [1:0]          o_neg_late
);

    mul_pkg::pp_neg_t                 neg_q;
    logic [mul_pkg::TREE_CARRY_W-1:0] col_carry [0:mul_pkg::PP_W-1];

    // negate carries follow the data across the mid-tree cut
    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            neg_q <= '0;
        end else begin
            neg_q <= i_neg;
        end
    end

    // the last two don't fit column 0, they go to the adder instead
    assign o_neg_late = neg_q[16:15];

    for (genvar c = 0; c < mul_pkg::PP_W; c++) begin : g_col
        logic [mul_pkg::PP_ROWS-1:0]      bits;
        logic [mul_pkg::TREE_CARRY_W-1:0] carry_in;

        for (genvar r = 0; r < mul_pkg::PP_ROWS; r++) begin : g_bit
            assign bits[r] = i_rows[r][c];
        end

        if (c == 0) begin : g_lsb
            // early slots take live carries, late slots the registered ones
            assign carry_in = {neg_q[14:11], i_neg[10:0]};
        end else begin : g_chain
            assign carry_in = col_carry[c-1];
        end

        wallace_column i_wallace_column (
            .i_clk      (i_clk),
            .i_resetn   (i_resetn),
            .i_bits     (bits),
            .i_carry    (carry_in),
            .o_carry    (col_carry[c]),
            .o_sum      (o_sum[c]),
            .o_carry_up (o_carry[c])
        );
    end

endmodule

/* hdl/wallace_column.sv */
`timescale 1ns/10ps

module wallace_column (
    input  logic                             i_clk,
    input  logic                             i_resetn,
    input  logic [mul_pkg::PP_ROWS-1:0]      i_bits,
    input  logic [mul_pkg::TREE_CARRY_W-1:0] i_carry,
    output logic [mul_pkg::TREE_CARRY_W-1:0] o_carry,
    output logic                             o_sum,
    output logic                             o_carry_up
);

    logic [4:0] s1;
    logic [3:0] s2;
    logic [1:0] s3;
    logic [1:0] s3_q;
    logic [3:0] cin_q;  // carries 7..10 from the next lower column
    logic [1:0] s4;
    logic       s5;
    logic       s6;

    // 3:2 counter returning {carry, sum}
    function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
        fa = {(a & b) | (a & c) | (b & c), a ^ b ^ c};
    endfunction

    // level 1 takes fifteen row bits into five adders
    for (genvar k = 0; k < 5; k++) begin : g_lvl1
        assign {o_carry[k], s1[k]} = fa(i_bits[3*k], i_bits[3*k+1], i_bits[3*k+2]);
    end

    // level 2
    assign {o_carry[5], s2[0]} = fa(s1[0], s1[1], s1[2]);
    assign {o_carry[6], s2[1]} = fa(s1[3], s1[4], i_bits[15]);
    assign {o_carry[7], s2[2]} = fa(i_carry[0], i_carry[1], i_carry[2]);
    assign {o_carry[8], s2[3]} = fa(i_carry[3], i_carry[4], i_bits[16]);

    // level 3
    assign {o_carry[9], s3[0]}  = fa(s2[0], s2[1], s2[2]);
    assign {o_carry[10], s3[1]} = fa(s2[3], i_carry[5], i_carry[6]);

    // pipeline cut
    always_ff @(posedge i_clk) begin
        if (!i_resetn) begin
            s3_q  <= '0;
            cin_q <= '0;
        end else begin
            s3_q  <= s3;
            cin_q <= i_carry[10:7];
        end
    end

    // everything below runs on last cycle's operands
    assign {o_carry[11], s4[0]} = fa(s3_q[0], s3_q[1], cin_q[0]);
    assign {o_carry[12], s4[1]} = fa(cin_q[1], cin_q[2], cin_q[3]);

    assign {o_carry[13], s5} = fa(s4[0], s4[1], i_carry[11]);
    assign {o_carry[14], s6} = fa(s5, i_carry[12], i_carry[13]);

    // last carry needs only a half adder
    assign o_sum      = s6 ^ i_carry[14];
    assign o_carry_up = s6 & i_carry[14];

    // late half comes up clean after reset
    a_cut_cleared : assert property (@(posedge i_clk)
        !i_resetn |=> !o_sum && !o_carry_up && (o_carry[14:11] == '0));

endmodule

/* hdl/booth_encoder.sv */
`timescale 1ns/10ps

module booth_encoder (
    input  mul_pkg::mul_operand_t i_x,
    input  mul_pkg::mul_operand_t i_y,
    input  logic                  i_mul_signed,
    output mul_pkg::pp_row_t      o_rows [0:mul_pkg::PP_ROWS-1],
    output mul_pkg::pp_neg_t      o_neg
);

    localparam int GUARD_W = mul_pkg::EXT_W - mul_pkg::OPERAND_W;
    localparam int SEXT_W  = mul_pkg::PP_W - mul_pkg::EXT_W;

    mul_pkg::mul_ext_t x_ext;
    mul_pkg::mul_ext_t y_ext;

    // unsigned mode just pads with zeros
    assign x_ext = {{GUARD_W{i_x[mul_pkg::OPERAND_W-1] & i_mul_signed}}, i_x};
    assign y_ext = {{GUARD_W{i_y[mul_pkg::OPERAND_W-1] & i_mul_signed}}, i_y};

    for (genvar r = 0; r < mul_pkg::PP_ROWS; r++) begin : g_row
        logic [2:0]       trip;
        logic             add_x;
        logic             add_2x;
        logic             sub_x;
        logic             sub_2x;
        mul_pkg::pp_row_t mcand;
        mul_pkg::pp_row_t mcand_2;

        // row 0 sees an implicit zero below the lsb
        if (r == 0) begin : g_first
            assign trip = {y_ext[1:0], 1'b0};
        end else begin : g_rest
            assign trip = y_ext[2*r+1 -: 3];
        end

        assign add_x  = (trip == 3'b001) || (trip == 3'b010);
        assign add_2x = (trip == 3'b011);
        assign sub_x  = (trip == 3'b101) || (trip == 3'b110);
        assign sub_2x = (trip == 3'b100);

        // multiplicand weighted by 4^r, sign carried to the full row width
        assign mcand   = {{SEXT_W{x_ext[mul_pkg::EXT_W-1]}}, x_ext} << (2 * r);
        assign mcand_2 = mcand << 1;

        // negative picks are one's complement, the +1 rides on o_neg
        assign o_rows[r] = ({mul_pkg::PP_W{add_x}}  & mcand)
                         | ({mul_pkg::PP_W{add_2x}} & mcand_2)
                         | ({mul_pkg::PP_W{sub_x}}  & ~mcand)
                         | ({mul_pkg::PP_W{sub_2x}} & ~mcand_2);

        assign o_neg[r] = sub_x | sub_2x;
    end

endmodule

/* hdl/mul_pkg.sv */
package mul_pkg;

    // operand and extension widths
    localparam int OPERAND_W    = 32;
    localparam int EXT_W        = 34; // two guard bits so unsigned fits a signed booth scan

    // booth rows, one per bit pair of the extended multiplier
    localparam int PP_ROWS      = 17;
    localparam int PP_W         = 68;

    localparam int PRODUCT_W    = 64;

    // carries handed from one wallace column to the next
    localparam int TREE_CARRY_W = 15;

    typedef logic [OPERAND_W-1:0]    mul_operand_t;
    typedef logic [EXT_W-1:0]        mul_ext_t;
    typedef logic [PP_W-1:0]         pp_row_t;
    typedef logic [PP_ROWS-1:0]      pp_neg_t;    // +1 for each subtracting row
    typedef logic [PP_W-1:0]         tree_vec_t;
    typedef logic [PRODUCT_W-1:0]    mul_product_t;

endpackage
